// ==== all.f ====
+incdir+include
verilog/afu_pkg.sv
verilog/axi_mem_if.sv
verilog/afu_reset_stretch.sv
verilog/afu_control.sv
verilog/axi_boundary_regs.sv
verilog/word_update_engine.sv
verilog/kernel_afu.sv
sim/tb_kernel_afu.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_kernel_afu
RTL_TOP    ?= kernel_afu
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
SOURCES    := $(wildcard verilog/*.sv sim/*.sv include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/tb_kernel_afu.sv ====
// Testbench for kernel_afu that runs random word-update jobs against a sparse AXI memory model
`timescale 1ns/1ps
`include "afu_defs.svh"

module tb_kernel_afu import afu_pkg::*; ();

  typedef logic [`AFU_ADDR_W-1:0]  addr_t;
  typedef logic [`AFU_DATA_W-1:0]  word_t;
  typedef logic [`AFU_COUNT_W-1:0] count_t;

  localparam int DONE_LIMIT = 4000;  // Cycles per job
  localparam int IDLE_LIMIT = 200;   // Reset hold plus margin

  logic ap_clk = 1'b0;
  logic ap_rst_n, ap_start, ap_idle, ap_done, ap_ready;
  logic [`AFU_BUF_W-1:0] buffer_0, buffer_1, buffer_2, buffer_3;
  logic m00_axi_arvalid, m00_axi_arready, m00_axi_rvalid, m00_axi_rready, m00_axi_rlast;
  logic m00_axi_awvalid, m00_axi_awready, m00_axi_wvalid, m00_axi_wready, m00_axi_wlast;
  logic m00_axi_bvalid, m00_axi_bready;
  logic [7:0] m00_axi_arlen, m00_axi_awlen;
  addr_t m00_axi_araddr, m00_axi_awaddr;
  word_t m00_axi_rdata, m00_axi_wdata;
  logic [`AFU_STRB_W-1:0] m00_axi_wstrb;

  logic [31:0] lfsr_state;
  word_t       mem_model [addr_t];  // Live memory
  word_t       exp_mem   [addr_t];  // Expected after the job
  logic        rd_expect [addr_t];  // Reads still owed
  logic        wr_expect [addr_t];  // Writes still owed
  int          ar_count, aw_count;

  kernel_afu dut_i (.*);

  always #50 ap_clk = ~ap_clk;  // 100 ns period

  // --------------------------------------------------------------------------
  // Random source and helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic addr_t word_addr(input addr_t base, input int i);
    return base + (addr_t'(i) << `AFU_WORD_SHIFT);
  endfunction

  function automatic word_t mem_read(input addr_t a);
    if (mem_model.exists(a)) return mem_model[a];
    return {a[31:0], a[63:32]} ^ 64'hc3a5_9669_0ff0_5aa5;  // Untouched location
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input addr_t addr, input word_t got,
                            input word_t exp);
    if (got !== exp)
      fail_now($sformatf("mismatch %s at 0x%016h got 0x%016h exp 0x%016h",
                         name, addr, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("mismatch %s got 0x%0h exp 0x%0h", name, got, exp));
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp) fail_now($sformatf("mismatch %s got 0x%0h exp 0x%0h", name, got, exp));
  endtask

  // --------------------------------------------------------------------------
  // AXI memory model sampling at negedge and driving 1 ns after posedge
  // --------------------------------------------------------------------------
  initial begin : axi_memory
    addr_t      rd_addr, aw_addr;
    word_t      w_data, nxt_rdata;
    logic       rd_pend, aw_have, w_have, b_pend;
    logic [1:0] r_wait, b_wait;
    logic       nxt_arready, nxt_awready, nxt_wready, nxt_rvalid, nxt_bvalid;
    m00_axi_arready = 1'b0;
    m00_axi_awready = 1'b0;
    m00_axi_wready  = 1'b0;
    m00_axi_rvalid  = 1'b0;
    m00_axi_rdata   = '0;
    m00_axi_rlast   = 1'b1;  // Single beat bursts only
    m00_axi_bvalid  = 1'b0;
    {rd_pend, aw_have, w_have, b_pend} = 4'b0;
    forever begin
      @(negedge ap_clk);
      {nxt_arready, nxt_awready, nxt_wready, nxt_rvalid, nxt_bvalid} = 5'b0;
      nxt_rdata = m00_axi_rdata;
      if (!ap_rst_n) begin
        {rd_pend, aw_have, w_have, b_pend} = 4'b0;
      end else begin
        nxt_rvalid = m00_axi_rvalid && !m00_axi_rready;  // Hold until taken
        nxt_bvalid = m00_axi_bvalid && !m00_axi_bready;
        if (m00_axi_arvalid && m00_axi_arready) begin
          if (rd_pend || !rd_expect.exists(m00_axi_araddr) || m00_axi_arlen != 8'd0)
            fail_now("read request is repeated, unexpected, overlapping or a burst");
          rd_expect.delete(m00_axi_araddr);
          ar_count++;
          rd_pend = 1'b1;
          rd_addr = m00_axi_araddr;
          r_wait  = 2'(rand_bits(2));  // R latency
        end
        if (m00_axi_awvalid && m00_axi_awready) begin
          if (aw_have || !wr_expect.exists(m00_axi_awaddr) || m00_axi_awlen != 8'd0)
            fail_now("write request is repeated, unexpected, overlapping or a burst");
          wr_expect.delete(m00_axi_awaddr);
          aw_count++;
          aw_have = 1'b1;
          aw_addr = m00_axi_awaddr;
        end
        if (m00_axi_wvalid && m00_axi_wready) begin
          if (w_have || m00_axi_wstrb != '1 || !m00_axi_wlast)
            fail_now("write data beat is not one full last beat");
          w_have = 1'b1;
          w_data = m00_axi_wdata;
        end
        if (aw_have && w_have) begin
          mem_model[aw_addr] = w_data;  // Commit once both halves arrived
          {aw_have, w_have} = 2'b0;
          b_pend = 1'b1;
          b_wait = 2'(rand_bits(2));
        end
        if (rd_pend && !nxt_rvalid) begin
          if (r_wait == 2'd0) begin
            nxt_rvalid = 1'b1;
            nxt_rdata  = mem_read(rd_addr);
            rd_pend    = 1'b0;
          end else r_wait--;
        end
        if (b_pend && !nxt_bvalid) begin
          if (b_wait == 2'd0) begin
            nxt_bvalid = 1'b1;
            b_pend     = 1'b0;
          end else b_wait--;
        end
        nxt_arready = 1'(rand_bits(1));  // Random stalls
        nxt_awready = 1'(rand_bits(1));
        nxt_wready  = 1'(rand_bits(1));
      end
      @(posedge ap_clk);
      #1;
      m00_axi_arready = nxt_arready;
      m00_axi_awready = nxt_awready;
      m00_axi_wready  = nxt_wready;
      m00_axi_rvalid  = nxt_rvalid;
      m00_axi_rdata   = nxt_rdata;
      m00_axi_bvalid  = nxt_bvalid;
    end
  end

  // --------------------------------------------------------------------------
  // Control waits and job runner
  // --------------------------------------------------------------------------
  task automatic wait_idle();
    int cyc;
    cyc = 0;
    do begin
      @(negedge ap_clk);
      cyc++;
      if (cyc > IDLE_LIMIT) fail_now("timeout waiting for ap_idle");
      check_flag("ap_done", ap_done, 1'b0);  // Single pulse only
    end while (!ap_idle);
  endtask

  task automatic wait_done();
    int cyc;
    cyc = 0;
    do begin
      @(negedge ap_clk);
      cyc++;
      if (cyc > DONE_LIMIT) fail_now("timeout waiting for ap_done");
    end while (!ap_done);
    check_flag("ap_ready", ap_ready, 1'b1);  // Same cycle as done
  endtask

  task automatic run_job(input logic endian, input logic empty);
    afu_descriptor_t job;
    addr_t           s, d;
    word_t           word;
    @(posedge ap_clk);
    #1;
    job.src_addr   = {28'(rand_bits(28)), 4'h1, 16'h0000, 13'(rand_bits(13)), 3'b000};
    job.dst_addr   = {28'(rand_bits(28)), 4'h2, 16'h0000, 13'(rand_bits(13)), 3'b000};
    job.word_count = empty ? '0 : count_t'(rand_bits(4)) + count_t'(1);  // 1 to 16
    job.endian     = endian;
    exp_mem = mem_model;
    rd_expect.delete();
    wr_expect.delete();
    ar_count = 0;
    aw_count = 0;
    for (int i = 0; i < int'(job.word_count); i++) begin
      s    = word_addr(job.src_addr, i);
      d    = word_addr(job.dst_addr, i);
      word = word_t'(rand_bits(64));
      mem_model[s] = word;
      exp_mem[s]   = word;
      exp_mem[d]   = swap_bytes64(swap_bytes64(word, endian) + word_t'(1), endian);
      rd_expect[s] = 1'b1;
      wr_expect[d] = 1'b1;
    end
    buffer_0 = job.src_addr;
    buffer_1 = job.dst_addr;
    buffer_2 = {32'(rand_bits(32)), job.word_count};  // Junk in the upper half
    buffer_3 = {63'(rand_bits(63)), job.endian};
    ap_start = 1'b1;
    @(posedge ap_clk);
    #1;
    ap_start = 1'b0;
    wait_done();
    wait_idle();
    check_count("ar handshakes", count_t'(ar_count), job.word_count);
    check_count("aw handshakes", count_t'(aw_count), job.word_count);
    check_count("memory entries", count_t'(mem_model.num()), count_t'(exp_mem.num()));
    foreach (mem_model[a]) begin
      if (!exp_mem.exists(a)) fail_now("memory written at an address outside the job");
      check_word("mem", a, mem_model[a], exp_mem[a]);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    lfsr_state = 32'h9d38_6e42;
    ap_rst_n   = 1'b0;
    ap_start   = 1'b0;
    buffer_0   = '0;
    buffer_1   = '0;
    buffer_2   = '0;
    buffer_3   = '0;
    repeat (10) @(posedge ap_clk);
    #1;
    ap_rst_n = 1'b1;
    wait_idle();
    check_flag("ap_ready", ap_ready, 1'b0);
    check_flag("m00_axi_arvalid", m00_axi_arvalid, 1'b0);
    check_flag("m00_axi_awvalid", m00_axi_awvalid, 1'b0);
    check_flag("m00_axi_wvalid", m00_axi_wvalid, 1'b0);
    check_flag("m00_axi_rready", m00_axi_rready, 1'b1);  // Responses always sunk
    check_flag("m00_axi_bready", m00_axi_bready, 1'b1);
    run_job(1'b0, 1'b0);  // Plain add-one
    run_job(1'b1, 1'b0);  // Byte swapped
    run_job(1'b0, 1'b1);  // Empty job
    run_job(1'b1, 1'b0);  // New buffers after a restart
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== verilog/kernel_afu.sv ====
// Kernel top level, wires reset, control, AXI boundary and the word-update engine together
`timescale 1ns/1ps
`include "afu_defs.svh"

module kernel_afu import afu_pkg::*; (
  input  logic                   ap_clk,
  input  logic                   ap_rst_n,
  input  logic                   ap_start,
  output logic                   ap_idle,
  output logic                   ap_done,
  output logic                   ap_ready,
  input  logic [`AFU_BUF_W-1:0]  buffer_0,
  input  logic [`AFU_BUF_W-1:0]  buffer_1,
  input  logic [`AFU_BUF_W-1:0]  buffer_2,
  input  logic [`AFU_BUF_W-1:0]  buffer_3,
  output logic                   m00_axi_arvalid,
  input  logic                   m00_axi_arready,
  output logic [`AFU_ADDR_W-1:0] m00_axi_araddr,
  output logic [7:0]             m00_axi_arlen,
  input  logic                   m00_axi_rvalid,
  output logic                   m00_axi_rready,
  input  logic [`AFU_DATA_W-1:0] m00_axi_rdata,
  input  logic                   m00_axi_rlast,
  output logic                   m00_axi_awvalid,
  input  logic                   m00_axi_awready,
  output logic [`AFU_ADDR_W-1:0] m00_axi_awaddr,
  output logic [7:0]             m00_axi_awlen,
  output logic                   m00_axi_wvalid,
  input  logic                   m00_axi_wready,
  output logic [`AFU_DATA_W-1:0] m00_axi_wdata,
  output logic [`AFU_STRB_W-1:0] m00_axi_wstrb,
  output logic                   m00_axi_wlast,
  input  logic                   m00_axi_bvalid,
  output logic                   m00_axi_bready
);

  // --------------------------------------------------------------------------
  // Internal wiring
  // --------------------------------------------------------------------------
  logic            areset;     // Stretched, active high
  afu_descriptor_t desc;
  logic            job_start;
  logic            job_done;
  axi_mem_if       mem_bus (); // Engine to boundary

  afu_reset_stretch reset_i (
    .ap_clk   (ap_clk),
    .ap_rst_n (ap_rst_n),
    .ap_done  (ap_done),
    .areset   (areset)
  );

  afu_control control_i (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .ap_start  (ap_start),
    .buffer_0  (buffer_0),
    .buffer_1  (buffer_1),
    .buffer_2  (buffer_2),
    .buffer_3  (buffer_3),
    .ap_idle   (ap_idle),
    .ap_done   (ap_done),
    .ap_ready  (ap_ready),
    .desc      (desc),
    .job_start (job_start),
    .job_done  (job_done)
  );

  axi_boundary_regs boundary_i (
    .ap_clk          (ap_clk),
    .areset          (areset),
    .endian          (desc.endian),  // Swap flag only
    .mem             (mem_bus.boundary),
    .m00_axi_arvalid (m00_axi_arvalid),
    .m00_axi_arready (m00_axi_arready),
    .m00_axi_araddr  (m00_axi_araddr),
    .m00_axi_arlen   (m00_axi_arlen),
    .m00_axi_rvalid  (m00_axi_rvalid),
    .m00_axi_rready  (m00_axi_rready),
    .m00_axi_rdata   (m00_axi_rdata),
    .m00_axi_rlast   (m00_axi_rlast),
    .m00_axi_awvalid (m00_axi_awvalid),
    .m00_axi_awready (m00_axi_awready),
    .m00_axi_awaddr  (m00_axi_awaddr),
    .m00_axi_awlen   (m00_axi_awlen),
    .m00_axi_wvalid  (m00_axi_wvalid),
    .m00_axi_wready  (m00_axi_wready),
    .m00_axi_wdata   (m00_axi_wdata),
    .m00_axi_wstrb   (m00_axi_wstrb),
    .m00_axi_wlast   (m00_axi_wlast),
    .m00_axi_bvalid  (m00_axi_bvalid),
    .m00_axi_bready  (m00_axi_bready)
  );

  word_update_engine engine_i (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .job_start  (job_start),
    .src_addr   (desc.src_addr),
    .dst_addr   (desc.dst_addr),
    .word_count (desc.word_count),
    .mem        (mem_bus.engine),
    .job_done   (job_done)
  );

endmodule

// ==== verilog/word_update_engine.sv ====
// Compute unit that reads N words from src, adds one, and writes them to dst in order
`timescale 1ns/1ps
`include "afu_defs.svh"

module word_update_engine import afu_pkg::*; (
  input  logic                    ap_clk,
  input  logic                    areset,
  input  logic                    job_start,
  input  logic [`AFU_ADDR_W-1:0]  src_addr,
  input  logic [`AFU_ADDR_W-1:0]  dst_addr,
  input  logic [`AFU_COUNT_W-1:0] word_count,
  axi_mem_if.engine               mem,
  output logic                    job_done    // One pulse per job
);

  engine_state_e          state;
  logic [`AFU_COUNT_W-1:0] idx;       // Current word
  logic [`AFU_COUNT_W-1:0] idx_nxt;
  logic [`AFU_ADDR_W-1:0]  offs;      // Byte offset of idx
  logic [`AFU_DATA_W-1:0]  wr_data;

  assign idx_nxt = idx + 1'b1;
  assign offs    = {{(`AFU_ADDR_W-`AFU_COUNT_W-`AFU_WORD_SHIFT){1'b0}}, idx,
                    {`AFU_WORD_SHIFT{1'b0}}};

  assign mem.rd_req  = (state == ENG_RD_REQ);
  assign mem.rd_addr = src_addr + offs;  // Stable until AR taken
  assign mem.wr_req  = (state == ENG_WR_REQ);
  assign mem.wr_addr = dst_addr + offs;
  assign mem.wr_data = wr_data;

  // --------------------------------------------------------------------------
  // Word loop FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      state    <= ENG_IDLE;
      idx      <= '0;
      job_done <= 1'b0;
    end else begin
      job_done <= 1'b0;
      case (state)
        ENG_IDLE: begin
          if (job_start) begin
            idx <= '0;
            if (word_count == '0) job_done <= 1'b1;  // Empty job without bus traffic
            else state <= ENG_RD_REQ;
          end
        end
        ENG_RD_REQ:  if (mem.rd_req_ready) state <= ENG_RD_WAIT;
        ENG_RD_WAIT: if (mem.rd_valid) state <= ENG_WR_REQ;
        ENG_WR_REQ:  if (mem.wr_req_ready) state <= ENG_WR_WAIT;
        ENG_WR_WAIT: begin
          if (mem.wr_done) begin
            idx <= idx_nxt;
            if (idx_nxt == word_count) begin
              job_done <= 1'b1;   // Last B beat seen
              state    <= ENG_IDLE;
            end else begin
              state <= ENG_RD_REQ;
            end
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  // Incremented word held until the write is taken
  always_ff @(posedge ap_clk) begin
    if (state == ENG_RD_WAIT && mem.rd_valid) wr_data <= mem.rd_data + 1'b1;
  end

  // No write request and no unfinished write in the boundary while idle
  a_no_idle_write : assert property (@(posedge ap_clk) disable iff (areset)
    state == ENG_IDLE |-> !mem.wr_req && mem.wr_req_ready);

endmodule

// ==== verilog/axi_boundary_regs.sv ====
// Registered single-beat AXI4 master slice between the engine and m00_axi, with byte swap
`timescale 1ns/1ps
`include "afu_defs.svh"

module axi_boundary_regs import afu_pkg::*; (
  input  logic                   ap_clk,
  input  logic                   areset,
  input  logic                   endian,           // Latched job flag
  axi_mem_if.boundary            mem,
  output logic                   m00_axi_arvalid,
  input  logic                   m00_axi_arready,
  output logic [`AFU_ADDR_W-1:0] m00_axi_araddr,
  output logic [7:0]             m00_axi_arlen,
  input  logic                   m00_axi_rvalid,
  output logic                   m00_axi_rready,
  input  logic [`AFU_DATA_W-1:0] m00_axi_rdata,
  input  logic                   m00_axi_rlast,
  output logic                   m00_axi_awvalid,
  input  logic                   m00_axi_awready,
  output logic [`AFU_ADDR_W-1:0] m00_axi_awaddr,
  output logic [7:0]             m00_axi_awlen,
  output logic                   m00_axi_wvalid,
  input  logic                   m00_axi_wready,
  output logic [`AFU_DATA_W-1:0] m00_axi_wdata,
  output logic [`AFU_STRB_W-1:0] m00_axi_wstrb,
  output logic                   m00_axi_wlast,
  input  logic                   m00_axi_bvalid,
  output logic                   m00_axi_bready
);

  logic resp_rdy;  // Shared R and B ready
  logic rd_take;
  logic wr_take;

  assign mem.rd_req_ready = !m00_axi_arvalid;                     // AR slot empty
  assign mem.wr_req_ready = !m00_axi_awvalid && !m00_axi_wvalid;  // Both slots empty
  assign rd_take = mem.rd_req && mem.rd_req_ready;
  assign wr_take = mem.wr_req && mem.wr_req_ready;

  // --------------------------------------------------------------------------
  // Valid and ready flops
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      m00_axi_arvalid <= 1'b0;
      m00_axi_awvalid <= 1'b0;
      m00_axi_wvalid  <= 1'b0;
      resp_rdy        <= 1'b0;
      mem.rd_valid    <= 1'b0;
      mem.wr_done     <= 1'b0;
    end else begin
      resp_rdy <= 1'b1;                     // Always sink R and B
      if (rd_take) m00_axi_arvalid <= 1'b1;
      else if (m00_axi_arready) m00_axi_arvalid <= 1'b0;
      if (wr_take) m00_axi_awvalid <= 1'b1;
      else if (m00_axi_awready) m00_axi_awvalid <= 1'b0;  // AW and W retire apart
      if (wr_take) m00_axi_wvalid <= 1'b1;
      else if (m00_axi_wready) m00_axi_wvalid <= 1'b0;
      mem.rd_valid <= m00_axi_rvalid && resp_rdy && m00_axi_rlast;
      mem.wr_done  <= m00_axi_bvalid && resp_rdy;
    end
  end

  // --------------------------------------------------------------------------
  // Payload flops, loaded only into an empty slot
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (rd_take) m00_axi_araddr <= mem.rd_addr;
    if (wr_take) begin
      m00_axi_awaddr <= mem.wr_addr;
      m00_axi_wdata  <= swap_bytes64(mem.wr_data, endian);  // Swap on the way out
    end
    mem.rd_data <= swap_bytes64(m00_axi_rdata, endian);     // Swap on the way in
  end

  assign m00_axi_rready = resp_rdy;
  assign m00_axi_bready = resp_rdy;
  assign m00_axi_arlen  = 8'd0;   // Single beat
  assign m00_axi_awlen  = 8'd0;
  assign m00_axi_wstrb  = '1;     // Full word writes
  assign m00_axi_wlast  = 1'b1;

  // Address held steady under AR back-pressure
  a_ar_stable : assert property (@(posedge ap_clk) disable iff (areset)
    m00_axi_arvalid && !m00_axi_arready |=> m00_axi_arvalid && $stable(m00_axi_araddr));

endmodule

// ==== verilog/afu_control.sv ====
// Kernel start/done/idle/ready handshake, latches the job descriptor and kicks the engine
`timescale 1ns/1ps
`include "afu_defs.svh"

module afu_control import afu_pkg::*; (
  input  logic                  ap_clk,
  input  logic                  areset,
  input  logic                  ap_start,
  input  logic [`AFU_BUF_W-1:0] buffer_0,   // Source base
  input  logic [`AFU_BUF_W-1:0] buffer_1,   // Destination base
  input  logic [`AFU_BUF_W-1:0] buffer_2,   // Word count
  input  logic [`AFU_BUF_W-1:0] buffer_3,   // Flags
  output logic                  ap_idle,
  output logic                  ap_done,
  output logic                  ap_ready,
  output afu_descriptor_t       desc,
  output logic                  job_start,  // One pulse per accepted start
  input  logic                  job_done
);

  afu_ctrl_state_e state;
  logic            start_take;

  assign start_take = (state == AFU_IDLE) && ap_start;

  // --------------------------------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      state     <= AFU_IDLE;
      ap_idle   <= 1'b0;          // Low until the hold window ends
      ap_done   <= 1'b0;
      ap_ready  <= 1'b0;
      job_start <= 1'b0;
    end else begin
      ap_done   <= 1'b0;          // Pulses by default
      ap_ready  <= 1'b0;
      job_start <= 1'b0;
      case (state)
        AFU_IDLE: begin
          ap_idle <= !ap_start;   // Drop idle as the job is taken
          if (ap_start) begin
            job_start <= 1'b1;    // Descriptor valid on the same edge
            state     <= AFU_RUN;
          end
        end
        AFU_RUN: begin
          if (job_done) begin
            ap_done  <= 1'b1;
            ap_ready <= 1'b1;
            state    <= AFU_DONE;
          end
        end
        default: state <= AFU_IDLE;  // Done cycle, reset hold follows
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Descriptor latch
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (start_take) begin
      desc.src_addr   <= buffer_0[`AFU_ADDR_W-1:0];
      desc.dst_addr   <= buffer_1[`AFU_ADDR_W-1:0];
      desc.word_count <= buffer_2[`AFU_COUNT_W-1:0];  // Upper half ignored
      desc.endian     <= buffer_3[`AFU_ENDIAN_BIT];
    end
  end

  // Done only ever follows a running job
  a_done_from_run : assert property (@(posedge ap_clk) disable iff (areset)
    $rose(ap_done) |-> $past(state) == AFU_RUN);

endmodule

// ==== verilog/afu_reset_stretch.sv ====
// Internal reset generator that holds areset after power-on reset and again after every ap_done
`timescale 1ns/1ps
`include "afu_defs.svh"

module afu_reset_stretch (
  input  logic ap_clk,
  input  logic ap_rst_n,
  input  logic ap_done,   // Retrigger after each job
  output logic areset
);

  logic [`AFU_RESET_HOLD-1:0] hold_sr;  // Ones drain out the top

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      hold_sr <= '1;                    // Immediate assert
    end else if (ap_done) begin
      hold_sr <= '1;                    // Restart the hold window
    end else begin
      hold_sr <= hold_sr << 1;          // Count down toward release
    end
  end

  assign areset = hold_sr[`AFU_RESET_HOLD-1];

  // Control block stays in reset for the whole hold window after it reports done
  a_done_resets : assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ap_done |=> areset ##(`AFU_RESET_HOLD-1) areset ##1 !areset);

endmodule

// ==== verilog/axi_mem_if.sv ====
// Single-word request bus from the compute engine to the registered AXI boundary
`timescale 1ns/1ps
`include "afu_defs.svh"

interface axi_mem_if;

  // --------------------------------------------------------------------------
  // Engine side requests
  // --------------------------------------------------------------------------
  logic                   rd_req;        // Read request, held until taken
  logic [`AFU_ADDR_W-1:0] rd_addr;
  logic                   wr_req;        // Write request, held until taken
  logic [`AFU_ADDR_W-1:0] wr_addr;
  logic [`AFU_DATA_W-1:0] wr_data;

  // --------------------------------------------------------------------------
  // Boundary side responses
  // --------------------------------------------------------------------------
  logic                   rd_req_ready;  // AR slot empty
  logic                   wr_req_ready;  // AW and W slots empty
  logic                   rd_valid;      // One-cycle pulse
  logic [`AFU_DATA_W-1:0] rd_data;       // Already endian corrected
  logic                   wr_done;       // One-cycle pulse per B beat

  modport engine (
    output rd_req, rd_addr, wr_req, wr_addr, wr_data,
    input  rd_req_ready, wr_req_ready, rd_valid, rd_data, wr_done
  );

  modport boundary (
    input  rd_req, rd_addr, wr_req, wr_addr, wr_data,
    output rd_req_ready, wr_req_ready, rd_valid, rd_data, wr_done
  );

endinterface

// ==== verilog/afu_pkg.sv ====
// Types and helpers shared by the kernel blocks and the testbench, imported per module
`include "afu_defs.svh"

package afu_pkg;

  // --------------------------------------------------------------------------
  // Job descriptor and state encodings
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [`AFU_ADDR_W-1:0]  src_addr;    // From buffer_0
    logic [`AFU_ADDR_W-1:0]  dst_addr;    // From buffer_1
    logic [`AFU_COUNT_W-1:0] word_count;  // From buffer_2
    logic                    endian;      // From buffer_3
  } afu_descriptor_t;

  typedef enum logic [1:0] {
    AFU_IDLE = 2'd0,  // Waiting for ap_start
    AFU_RUN  = 2'd1,  // Engine busy
    AFU_DONE = 2'd2   // ap_done cycle
  } afu_ctrl_state_e;

  typedef enum logic [2:0] {
    ENG_IDLE    = 3'd0,
    ENG_RD_REQ  = 3'd1,  // Offer read address
    ENG_RD_WAIT = 3'd2,  // Wait for R beat
    ENG_WR_REQ  = 3'd3,  // Offer write address and data
    ENG_WR_WAIT = 3'd4   // Wait for B beat
  } engine_state_e;

  // Byte reversal of one 64-bit word, pass-through when en is low
  function automatic logic [63:0] swap_bytes64(input logic [63:0] word, input logic en);
    logic [63:0] swapped;
    for (int b = 0; b < 8; b++) begin
      swapped[8*b +: 8] = word[8*(7-b) +: 8];
    end
    return en ? swapped : word;
  endfunction

endpackage

// ==== include/afu_defs.svh ====
// Bus widths, reset hold count and argument layout, included by any file that sizes a port
`ifndef AFU_DEFS_SVH
`define AFU_DEFS_SVH

// ----------------------------------------------------------------------------
// AXI4 master sizing
// ----------------------------------------------------------------------------
`define AFU_ADDR_W      64                 // Byte address width
`define AFU_DATA_W      64                 // One word per beat
`define AFU_STRB_W      (`AFU_DATA_W / 8)  // Byte enables per beat
`define AFU_WORD_SHIFT  3                  // Log2 of bytes per word

// ----------------------------------------------------------------------------
// Kernel arguments and reset
// ----------------------------------------------------------------------------
`define AFU_BUF_W       64                 // Width of each buffer_N argument
`define AFU_COUNT_W     32                 // Word count, low bits of buffer_2
`define AFU_ENDIAN_BIT  0                  // Swap enable inside buffer_3
`define AFU_RESET_HOLD  40                 // Cycles areset stays high

`endif
